/* link_pkg.sv */
`default_nettype none

package link_pkg;

  // one data byte, counter value or received byte
  typedef logic [7:0] byte_t;

  // burst length from the switches, zero sends nothing
  typedef logic [4:0] burst_t;

  // active-low segments, bit 6 is g and bit 0 is a
  typedef logic [6:0] seg_t;

  // clk cycles per bit tick
  localparam int TICK_DIV_DEFAULT = 4;

  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_send,
    ctrl_wait_done
  } ctrl_state_t;

  // each state names the bit placed on the line at the next tick
  typedef enum logic [2:0] {
    tx_idle,
    tx_start_bit,
    tx_data_bits,
    tx_stop_bit,
    tx_wait_ack
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_data_bits,
    rx_stop_bit
  } rx_state_t;

endpackage

`default_nettype wire

/* link_tx_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface link_tx_if;
  import link_pkg::*;

  // one-cycle request, only while busy is low
  logic  go;
  // held stable by the controller while busy
  byte_t data;
  logic  busy;
  // one-cycle pulse, same cycle that busy falls
  logic  end_tx;

  modport ctrl (
    output go,
    output data,
    input  busy,
    input  end_tx
  );

  modport tx (
    input  go,
    input  data,
    output busy,
    output end_tx
  );

endinterface

`default_nettype wire

/* tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
  parameter int TICK_DIV = link_pkg::TICK_DIV_DEFAULT
) (
  input  logic clk,
  input  logic rst,
  input  logic ena,
  output logic tick
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0] cnt;
  logic             last;

  assign last = (cnt == CNT_W'(TICK_DIV - 1));

  // no tick while ena is low, the count holds where it is
  assign tick = ena & last;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (ena) begin
      if (last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* link_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module link_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  link_pkg::burst_t      burst_len,
  link_tx_if.ctrl               tx,
  output link_pkg::byte_t       ext_counter,
  output link_pkg::ctrl_state_t state_ctrl
);
  import link_pkg::*;

  ctrl_state_t state;
  burst_t      remaining;
  logic        start_q;
  logic        start_rise;

  assign start_rise = start & ~start_q;

  // frame payload is the counter value itself
  assign tx.data = ext_counter;
  assign tx.go   = (state == ctrl_send) & ~tx.busy;

  assign state_ctrl = state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ctrl_idle;
      remaining   <= '0;
      start_q     <= 1'b0;
      ext_counter <= '0;
    end else begin
      start_q <= start;

      // count only frames the peer acknowledged
      if (tx.end_tx) begin
        ext_counter <= ext_counter + 1'b1;
      end

      case (state)
        ctrl_idle: begin
          // edges outside idle are dropped
          if (start_rise && burst_len != '0) begin
            remaining <= burst_len;
            state     <= ctrl_send;
          end
        end
        ctrl_send: begin
          if (!tx.busy) begin
            remaining <= remaining - 1'b1;
            state     <= ctrl_wait_done;
          end
        end
        ctrl_wait_done: begin
          if (tx.end_tx) begin
            state <= (remaining == '0) ? ctrl_idle : ctrl_send;
          end
        end
        default: state <= ctrl_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* serial_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_tx (
  input  logic                clk,
  input  logic                rst,
  input  logic                tick,
  link_tx_if.tx               tx,
  input  logic                ack_in,
  output logic                ext_data_out,
  output link_pkg::tx_state_t state_tx
);
  import link_pkg::*;

  tx_state_t state;
  byte_t     shreg;
  logic [2:0] bit_cnt;

  assign state_tx = state;

  // payload shift register
  always_ff @(posedge clk) begin
    if (state == tx_idle && tx.go) begin
      shreg <= tx.data;
    end else if (state == tx_data_bits && tick) begin
      shreg <= shreg >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= tx_idle;
      ext_data_out <= 1'b1;
      bit_cnt      <= '0;
      tx.busy      <= 1'b0;
      tx.end_tx    <= 1'b0;
    end else begin
      tx.end_tx <= 1'b0;

      case (state)
        tx_idle: begin
          if (tx.go) begin
            tx.busy <= 1'b1;
            state   <= tx_start_bit;
          end
        end
        tx_start_bit: begin
          if (tick) begin
            ext_data_out <= 1'b0;
            bit_cnt      <= '0;
            state        <= tx_data_bits;
          end
        end
        tx_data_bits: begin
          // lsb first, one bit per tick
          if (tick) begin
            ext_data_out <= shreg[0];
            bit_cnt      <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= tx_stop_bit;
            end
          end
        end
        tx_stop_bit: begin
          if (tick) begin
            ext_data_out <= 1'b1;
            state        <= tx_wait_ack;
          end
        end
        tx_wait_ack: begin
          // line stays high, no limit on the wait
          if (ack_in) begin
            tx.busy   <= 1'b0;
            tx.end_tx <= 1'b1;
            state     <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* serial_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_rx (
  input  logic            clk,
  input  logic            rst,
  input  logic            tick,
  input  logic            ext_data_in,
  output logic            ack_out,
  output link_pkg::byte_t rx_data,
  output link_pkg::byte_t rx_count
);
  import link_pkg::*;

  rx_state_t  state;
  byte_t      shreg;
  logic [2:0] bit_cnt;

  // bits arrive lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == rx_data_bits && tick) begin
      shreg <= {ext_data_in, shreg[7:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= rx_idle;
      bit_cnt  <= '0;
      ack_out  <= 1'b0;
      rx_data  <= '0;
      rx_count <= '0;
    end else begin
      ack_out <= 1'b0;

      if (tick) begin
        case (state)
          rx_idle: begin
            // low sample means start bit
            if (!ext_data_in) begin
              bit_cnt <= '0;
              state   <= rx_data_bits;
            end
          end
          rx_data_bits: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop_bit;
            end
          end
          rx_stop_bit: begin
            // bad stop bit drops the frame silently
            if (ext_data_in) begin
              rx_data  <= shreg;
              rx_count <= rx_count + 1'b1;
              ack_out  <= 1'b1;
            end
            state <= rx_idle;
          end
          default: state <= rx_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* link_node.sv */
`timescale 1ns/1ps
`default_nettype none

module link_node #(
  parameter int TICK_DIV = link_pkg::TICK_DIV_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ena,
  input  logic                start,
  input  link_pkg::burst_t    burst_len,
  input  logic                ext_data_in,
  input  logic                ack_in,
  output logic                ext_data_out,
  output logic                ack_out,
  output logic                end_tx,
  output link_pkg::byte_t     ext_counter,
  output link_pkg::byte_t     rx_data,
  output link_pkg::byte_t     rx_count,
  output link_pkg::tx_state_t state_tx
);

  logic tick;

  link_tx_if tx_bus ();

  assign end_tx = tx_bus.end_tx;

  tick_gen #(
    .TICK_DIV (TICK_DIV)
  ) u_tick (
    .clk  (clk),
    .rst  (rst),
    .ena  (ena),
    .tick (tick)
  );

  // controller state is only for debug, not brought out
  link_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .burst_len   (burst_len),
    .tx          (tx_bus.ctrl),
    .ext_counter (ext_counter),
    .state_ctrl  ()
  );

  serial_tx u_tx (
    .clk          (clk),
    .rst          (rst),
    .tick         (tick),
    .tx           (tx_bus.tx),
    .ack_in       (ack_in),
    .ext_data_out (ext_data_out),
    .state_tx     (state_tx)
  );

  serial_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .ext_data_in (ext_data_in),
    .ack_out     (ack_out),
    .rx_data     (rx_data),
    .rx_count    (rx_count)
  );

endmodule

`default_nettype wire

/* char7.sv */
`timescale 1ns/1ps
`default_nettype none

module char7 (
  input  logic [3:0]     digit,
  output link_pkg::seg_t seg
);

  // segments g..a, a zero lights the segment
  always_comb begin
    case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
  end

endmodule

`default_nettype wire

/* link_pair_top.sv */
`timescale 1ns/1ps
`default_nettype none

module link_pair_top #(
  parameter int TICK_DIV = link_pkg::TICK_DIV_DEFAULT
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ena,
  input  logic       start,
  input  logic [4:0] state_in,
  output logic       end_tx,
  output logic       line_a,
  output logic [7:0] counter_a,
  output logic [7:0] rx_data_b,
  output logic [7:0] rx_count_b,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5,
  output logic [6:0] hex6,
  output logic [6:0] hex7
);
  import link_pkg::*;

  // cross-connected serial and ack lines
  logic  line_b;
  logic  ack_a;
  logic  ack_b;
  byte_t counter_b;

  // node A sends the bursts
  link_node #(
    .TICK_DIV (TICK_DIV)
  ) node_a (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .start        (start),
    .burst_len    (state_in),
    .ext_data_in  (line_b),
    .ack_in       (ack_b),
    .ext_data_out (line_a),
    .ack_out      (ack_a),
    .end_tx       (end_tx),
    .ext_counter  (counter_a),
    .rx_data      (),
    .rx_count     (),
    .state_tx     ()
  );

  // node B only receives, start tied off
  link_node #(
    .TICK_DIV (TICK_DIV)
  ) node_b (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .start        (1'b0),
    .burst_len    (5'd0),
    .ext_data_in  (line_a),
    .ack_in       (ack_a),
    .ext_data_out (line_b),
    .ack_out      (ack_b),
    .end_tx       (),
    .ext_counter  (counter_b),
    .rx_data      (rx_data_b),
    .rx_count     (rx_count_b),
    .state_tx     ()
  );

  char7 u_hex0 (.digit (counter_a[3:0]),  .seg (hex0));
  char7 u_hex1 (.digit (counter_a[7:4]),  .seg (hex1));
  char7 u_hex2 (.digit (rx_count_b[3:0]), .seg (hex2));
  char7 u_hex3 (.digit (rx_count_b[7:4]), .seg (hex3));
  char7 u_hex4 (.digit (counter_b[3:0]),  .seg (hex4));
  char7 u_hex5 (.digit (counter_b[7:4]),  .seg (hex5));
  char7 u_hex6 (.digit (rx_data_b[3:0]),  .seg (hex6));
  char7 u_hex7 (.digit (rx_data_b[7:4]),  .seg (hex7));

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RST_CYCLES     = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // reset released on a rising edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* link_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module link_assert (
  input logic       clk,
  input logic       rst,
  input logic       ena,
  input logic       end_tx,
  input logic       line_a,
  input logic [7:0] counter_a,
  input logic [7:0] rx_data_b,
  input logic [7:0] rx_count_b
);

  int fail_cnt = 0;

  // outputs come out of reset idle and cleared
  a_reset_values: assert property (@(posedge clk)
    rst |=> (line_a && !end_tx && counter_a == 8'h00 &&
             rx_count_b == 8'h00 && rx_data_b == 8'h00))
    else begin
      fail_cnt++;
      $error("outputs not at reset values");
    end

  // each acknowledged frame adds one to the count
  a_count_step: assert property (@(posedge clk) disable iff (rst)
    end_tx |=> counter_a == $past(counter_a) + 8'd1)
    else begin
      fail_cnt++;
      $error("counter_a did not step by one on end_tx");
    end

  a_count_hold: assert property (@(posedge clk) disable iff (rst)
    !end_tx |=> $stable(counter_a))
    else begin
      fail_cnt++;
      $error("counter_a changed without end_tx");
    end

  // receiver counted the frame before the sender saw the ack
  a_count_match: assert property (@(posedge clk) disable iff (rst)
    end_tx |=> rx_count_b == counter_a)
    else begin
      fail_cnt++;
      $error("rx_count_b differs from counter_a after end_tx");
    end

  // payload is the sender's count before this frame completes
  a_rx_payload: assert property (@(posedge clk) disable iff (rst)
    (rx_count_b != $past(rx_count_b)) |-> rx_data_b == counter_a)
    else begin
      fail_cnt++;
      $error("rx_data_b is not the sent counter value");
    end

  // stalled ticks freeze the line
  a_line_frozen: assert property (@(posedge clk) disable iff (rst)
    !ena |=> $stable(line_a))
    else begin
      fail_cnt++;
      $error("line_a moved while ena was low");
    end

  a_no_end_stalled: assert property (@(posedge clk) disable iff (rst)
    (!ena ##1 !ena) |=> !end_tx)
    else begin
      fail_cnt++;
      $error("end_tx fired while ena was low");
    end

endmodule

bind link_pair_top link_assert u_chk (
  .clk        (clk),
  .rst        (rst),
  .ena        (ena),
  .end_tx     (end_tx),
  .line_a     (line_a),
  .counter_a  (counter_a),
  .rx_data_b  (rx_data_b),
  .rx_count_b (rx_count_b)
);

`default_nettype wire

/* link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module link_tb;

  logic       clk;
  logic       rst;
  logic       ena;
  logic       start;
  logic [4:0] state_in;
  logic       end_tx;
  logic       line_a;
  logic [7:0] counter_a;
  logic [7:0] rx_data_b;
  logic [7:0] rx_count_b;
  logic [6:0] hex [8];

  // acknowledged frames seen on end_tx, and frames requested by bursts
  int unsigned frames_done;
  int unsigned frames_sent;
  logic [7:0]  last_rx_count;
  int unsigned seed;
  int unsigned n;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  link_pair_top #(
    .TICK_DIV (4)
  ) dut (
    .clk (clk), .rst (rst), .ena (ena), .start (start), .state_in (state_in),
    .end_tx (end_tx), .line_a (line_a), .counter_a (counter_a),
    .rx_data_b (rx_data_b), .rx_count_b (rx_count_b),
    .hex0 (hex[0]), .hex1 (hex[1]), .hex2 (hex[2]), .hex3 (hex[3]),
    .hex4 (hex[4]), .hex5 (hex[5]), .hex6 (hex[6]), .hex7 (hex[7])
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // invert the lit gfedcba segments of each digit for the active-low pattern
  function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
    logic [6:0] lit [16];
    lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
            7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    return ~lit[nib];
  endfunction

  task automatic check_seg(input int idx, input logic [3:0] nib);
    if (hex[idx] !== seg_pattern(nib)) begin
      report_failure($sformatf("Mismatch hex%0d: got 0x%h, expected 0x%h",
                               idx, hex[idx], seg_pattern(nib)));
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      frames_done   = 0;
      last_rx_count = 8'h00;
    end else begin
      if (dut.u_chk.fail_cnt != 0) begin
        report_failure("a concurrent assertion on the link failed");
      end
      if (rx_count_b !== last_rx_count) begin
        if (rx_data_b !== frames_done[7:0]) begin
          report_failure($sformatf("Mismatch rx_data_b: got 0x%h, expected 0x%h",
                                   rx_data_b, frames_done[7:0]));
        end
        last_rx_count = rx_count_b;
      end
      if (end_tx) begin
        frames_done++;
      end
      check_seg(0, counter_a[3:0]);
      check_seg(1, counter_a[7:4]);
      check_seg(2, rx_count_b[3:0]);
      check_seg(3, rx_count_b[7:4]);
      // node B never sends, so its counter stays zero
      check_seg(4, 4'h0);
      check_seg(5, 4'h0);
      check_seg(6, rx_data_b[3:0]);
      check_seg(7, rx_data_b[7:4]);
    end
  end

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    while (rst && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (rst) begin
      report_failure("reset was never released");
    end
  endtask

  // hold ena low for a while inside a frame
  task automatic stall_mid_frame();
    int cycles;
    cycles = 0;
    while (line_a && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (line_a) begin
      report_failure("no start bit appeared on line_a");
    end
    repeat (4 + $urandom_range(20, 0)) @(posedge clk);
    ena <= 1'b0;
    repeat (5 + $urandom_range(30, 0)) @(posedge clk);
    ena <= 1'b1;
  endtask

  task automatic run_burst(input int unsigned len, input bit disturb);
    int cycles;
    frames_sent += len;
    @(posedge clk);
    state_in <= len[4:0];
    start    <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (len != 0 && disturb) begin
      stall_mid_frame();
      // a second press while busy must be ignored
      @(posedge clk);
      state_in <= 5'd31;
      start    <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    cycles = 0;
    while (counter_a !== frames_sent[7:0] && cycles < 4000) begin
      @(negedge clk);
      cycles++;
    end
    if (counter_a !== frames_sent[7:0]) begin
      report_failure("timed out waiting for the burst to finish");
    end
    // long enough for one more frame to show up if one was started
    repeat (120) @(negedge clk);
    if (counter_a !== frames_sent[7:0]) begin
      report_failure($sformatf("Mismatch counter_a: got 0x%h, expected 0x%h",
                               counter_a, frames_sent[7:0]));
    end
  endtask

  initial begin
    seed = 28591;
    void'($urandom(seed));
    ena         = 1'b1;
    start       = 1'b0;
    state_in    = 5'd0;
    frames_sent = 0;
    wait_reset_done();
    run_burst(0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      n = $urandom_range(8, 1);
      run_burst(n, i[0]);
    end
    run_burst(0, 1'b1);
    if (dut.u_chk.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_failure("a concurrent assertion on the link failed");
    end
  end

endmodule

`default_nettype wire

/* src.f */
link_pkg.sv
link_tx_if.sv
tick_gen.sv
link_ctrl.sv
serial_tx.sv
serial_rx.sv
link_node.sv
char7.sv
link_pair_top.sv
tb_clock.sv
link_assert.sv
link_tb.sv
